/* src/rv_pipe_pkg.sv */
package rv_pipe_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;      // Data, addresses and instructions
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [4:0]      alu_op_t;

  // ####################################################################
  // RV32I opcode map, inst[6:0]
  // ####################################################################
  localparam opcode_t OP_R       = 7'b0110011;
  localparam opcode_t OP_I_ARITH = 7'b0010011;
  localparam opcode_t OP_I_LOAD  = 7'b0000011;
  localparam opcode_t OP_S       = 7'b0100011;
  localparam opcode_t OP_B       = 7'b1100011;

  // ####################################################################
  // ALU operations
  // ####################################################################
  // Top bit selects the subtract path
  localparam alu_op_t ALU_ADD = 5'b00000;
  localparam alu_op_t ALU_SUB = 5'b10000;
  localparam alu_op_t ALU_AND = 5'b00001;
  localparam alu_op_t ALU_OR  = 5'b00010;
  localparam alu_op_t ALU_XOR = 5'b00011;
  localparam alu_op_t ALU_SLL = 5'b00100;

  // ####################################################################
  // Branch funct3
  // ####################################################################
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
  input  rv_pipe_pkg::word_t   a,
  input  rv_pipe_pkg::word_t   b,
  input  rv_pipe_pkg::alu_op_t alu_op,
  output rv_pipe_pkg::word_t   result,
  output logic                 n,
  output logic                 z,
  output logic                 c,
  output logic                 v
);

  logic [rv_pipe_pkg::XLEN:0] sub_full;   // Carry out in the top bit
  rv_pipe_pkg::word_t         diff;

  // a + ~b + 1, carry high means no unsigned borrow
  assign sub_full = {1'b0, a} + {1'b0, ~b} + 1'b1;
  assign diff     = sub_full[rv_pipe_pkg::XLEN-1:0];

  assign n = diff[rv_pipe_pkg::XLEN-1];
  assign z = (diff == '0);
  assign c = sub_full[rv_pipe_pkg::XLEN];
  // Signs of operands differ and result sign flips away from a
  assign v = (a[rv_pipe_pkg::XLEN-1] != b[rv_pipe_pkg::XLEN-1]) &&
             (diff[rv_pipe_pkg::XLEN-1] != a[rv_pipe_pkg::XLEN-1]);

  always_comb
  begin
    case (alu_op)
      rv_pipe_pkg::ALU_SUB: result = diff;
      rv_pipe_pkg::ALU_AND: result = a & b;
      rv_pipe_pkg::ALU_OR:  result = a | b;
      rv_pipe_pkg::ALU_XOR: result = a ^ b;
      rv_pipe_pkg::ALU_SLL: result = a << b[4:0];
      default:              result = a + b;
    endcase
  end

endmodule

/* src/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  rv_pipe_pkg::word_t   if_id_inst,
  output logic                 reg_write,
  output logic                 alu_src,
  output logic                 mem_to_reg,
  output logic                 mem_write,
  output logic                 mem_read,
  output logic                 branch,
  output rv_pipe_pkg::alu_op_t alu_op
);

  logic [6:0] funct7;
  logic [2:0] funct3;

  assign funct7 = if_id_inst[31:25];
  assign funct3 = if_id_inst[14:12];

  always_comb
  begin
    reg_write  = 1'b0;
    alu_src    = 1'b0;
    mem_to_reg = 1'b0;
    mem_write  = 1'b0;
    mem_read   = 1'b0;
    branch     = 1'b0;
    alu_op     = rv_pipe_pkg::ALU_ADD;
    case (rv_pipe_pkg::opcode_t'(if_id_inst[6:0]))
      rv_pipe_pkg::OP_R:
      begin
        reg_write = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: alu_op = rv_pipe_pkg::ALU_ADD;
          10'b0100000_000: alu_op = rv_pipe_pkg::ALU_SUB;
          10'b0000000_111: alu_op = rv_pipe_pkg::ALU_AND;
          10'b0000000_110: alu_op = rv_pipe_pkg::ALU_OR;
          default:         reg_write = 1'b0;   // Unsupported R-type
        endcase
      end
      rv_pipe_pkg::OP_I_ARITH:
      begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
        case (funct3)
          3'b000:  alu_op = rv_pipe_pkg::ALU_ADD;
          3'b100:  alu_op = rv_pipe_pkg::ALU_XOR;
          3'b110:  alu_op = rv_pipe_pkg::ALU_OR;
          3'b111:  alu_op = rv_pipe_pkg::ALU_AND;
          3'b001:
          begin
            alu_op    = rv_pipe_pkg::ALU_SLL;
            reg_write = (funct7 == 7'b0000000);  // slli only
          end
          default: reg_write = 1'b0;
        endcase
      end
      rv_pipe_pkg::OP_I_LOAD:
      begin
        reg_write  = 1'b1;
        alu_src    = 1'b1;
        mem_to_reg = 1'b1;
        mem_read   = 1'b1;
      end
      rv_pipe_pkg::OP_S:
      begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
      end
      rv_pipe_pkg::OP_B:
      begin
        branch = 1'b1;
        alu_op = rv_pipe_pkg::ALU_SUB;   // Flags from a - b
      end
      default: ;
    endcase
  end

endmodule

/* src/regfile.sv */
`timescale 1ns/1ps

module regfile (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   we,
  input  rv_pipe_pkg::reg_addr_t rs1,
  input  rv_pipe_pkg::reg_addr_t rs2,
  input  rv_pipe_pkg::reg_addr_t rd,
  input  rv_pipe_pkg::word_t     rd_data,
  output rv_pipe_pkg::word_t     rs1_data,
  output rv_pipe_pkg::word_t     rs2_data
);

  rv_pipe_pkg::word_t regs [32];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (we && rd != '0)
      regs[rd] <= rd_data;   // Writes to x0 are dropped
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (reset)
    (rs1 == '0 |-> rs1_data == '0) and (rs2 == '0 |-> rs2_data == '0));

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
  input  rv_pipe_pkg::word_t     if_id_inst,
  input  rv_pipe_pkg::reg_addr_t ex_rd,
  input  rv_pipe_pkg::reg_addr_t mem_rd,
  input  rv_pipe_pkg::reg_addr_t wb_rd,
  input  logic                   ex_reg_write,
  input  logic                   ex_mem_read,
  input  logic                   mem_reg_write,
  input  logic                   mem_is_load,
  input  logic                   wb_we,
  input  rv_pipe_pkg::word_t     ex_result,
  input  rv_pipe_pkg::word_t     mem_rdata,
  input  rv_pipe_pkg::word_t     mem_result,
  input  rv_pipe_pkg::word_t     wb_data,
  input  rv_pipe_pkg::word_t     rf_rs1_data,
  input  rv_pipe_pkg::word_t     rf_rs2_data,
  output logic                   stall,
  output rv_pipe_pkg::word_t     rs1_data,
  output rv_pipe_pkg::word_t     rs2_data
);

  rv_pipe_pkg::reg_addr_t rs1;
  rv_pipe_pkg::reg_addr_t rs2;

  assign rs1 = if_id_inst[19:15];
  assign rs2 = if_id_inst[24:20];

  // Youngest producer wins
  function automatic rv_pipe_pkg::word_t fwd(input rv_pipe_pkg::reg_addr_t src,
                                             input rv_pipe_pkg::word_t rf_data);
    if (src == '0)
      return rf_data;
    else if (ex_reg_write && !ex_mem_read && ex_rd == src)
      return ex_result;
    else if (mem_reg_write && mem_is_load && mem_rd == src)
      return mem_rdata;                    // Load data straight from memory
    else if (mem_reg_write && mem_rd == src)
      return mem_result;
    else if (wb_we && wb_rd == src)
      return wb_data;
    else
      return rf_data;
  endfunction

  always_comb
  begin
    rs1_data = fwd(rs1, rf_rs1_data);
    rs2_data = fwd(rs2, rf_rs2_data);
  end

  // Load in execute feeding decode, wait one cycle
  assign stall = ex_mem_read && (ex_rd != '0) && (ex_rd == rs1 || ex_rd == rs2);

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
  parameter rv_pipe_pkg::word_t RESET_PC = '0
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,
  input  logic               branch_taken,
  input  rv_pipe_pkg::word_t branch_target,
  input  rv_pipe_pkg::word_t inst,
  output rv_pipe_pkg::word_t pc,
  output rv_pipe_pkg::word_t if_id_inst,
  output rv_pipe_pkg::word_t if_id_pc
);

  // ####################################################################
  // Program counter, predict not taken
  // ####################################################################
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= RESET_PC;
    else if (branch_taken)
      pc <= branch_target;     // Redirect beats stall
    else if (!stall)
      pc <= pc + 32'd4;
  end

  // ####################################################################
  // IF/ID register
  // ####################################################################
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      if_id_inst <= '0;        // Zero decodes as a bubble
      if_id_pc   <= '0;
    end
    else if (branch_taken)
    begin
      if_id_inst <= '0;        // Squash wrong-path fetch
      if_id_pc   <= '0;
    end
    else if (!stall)
    begin
      if_id_inst <= inst;
      if_id_pc   <= pc;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00);

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stall,
  input  logic                   branch_taken,
  input  rv_pipe_pkg::word_t     if_id_inst,
  input  rv_pipe_pkg::word_t     if_id_pc,
  input  rv_pipe_pkg::word_t     rs1_data,
  input  rv_pipe_pkg::word_t     rs2_data,
  input  logic                   reg_write,
  input  logic                   alu_src,
  input  logic                   mem_to_reg,
  input  logic                   mem_write,
  input  logic                   mem_read,
  input  logic                   branch,
  input  rv_pipe_pkg::alu_op_t   alu_op,
  output logic                   id_ex_reg_write,
  output logic                   id_ex_alu_src,
  output logic                   id_ex_mem_to_reg,
  output logic                   id_ex_mem_write,
  output logic                   id_ex_mem_read,
  output logic                   id_ex_branch,
  output rv_pipe_pkg::alu_op_t   id_ex_alu_op,
  output rv_pipe_pkg::reg_addr_t id_ex_rd,
  output logic [2:0]             id_ex_funct3,
  output rv_pipe_pkg::word_t     id_ex_rs1_data,
  output rv_pipe_pkg::word_t     id_ex_rs2_data,
  output rv_pipe_pkg::word_t     id_ex_pc,
  output rv_pipe_pkg::word_t     id_ex_imm
);

  rv_pipe_pkg::word_t imm;
  logic               bubble;

  // Immediate by format
  always_comb
  begin
    case (rv_pipe_pkg::opcode_t'(if_id_inst[6:0]))
      rv_pipe_pkg::OP_S: imm = {{20{if_id_inst[31]}}, if_id_inst[31:25], if_id_inst[11:7]};
      rv_pipe_pkg::OP_B: imm = {{20{if_id_inst[31]}}, if_id_inst[7], if_id_inst[30:25],
                                if_id_inst[11:8], 1'b0};
      default:           imm = {{20{if_id_inst[31]}}, if_id_inst[31:20]};  // I-type
    endcase
  end

  assign bubble = stall || branch_taken;

  // Control half of ID/EX
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset || bubble)
    begin
      id_ex_reg_write  <= 1'b0;
      id_ex_alu_src    <= 1'b0;
      id_ex_mem_to_reg <= 1'b0;
      id_ex_mem_write  <= 1'b0;
      id_ex_mem_read   <= 1'b0;
      id_ex_branch     <= 1'b0;
      id_ex_alu_op     <= rv_pipe_pkg::ALU_ADD;
    end
    else
    begin
      id_ex_reg_write  <= reg_write;
      id_ex_alu_src    <= alu_src;
      id_ex_mem_to_reg <= mem_to_reg;
      id_ex_mem_write  <= mem_write;
      id_ex_mem_read   <= mem_read;
      id_ex_branch     <= branch;
      id_ex_alu_op     <= alu_op;
    end
  end

  // Data half, meaningless once the controls are cleared
  always_ff @(posedge clk)
  begin
    id_ex_rd       <= if_id_inst[11:7];
    id_ex_funct3   <= if_id_inst[14:12];
    id_ex_rs1_data <= rs1_data;
    id_ex_rs2_data <= rs2_data;
    id_ex_pc       <= if_id_pc;
    id_ex_imm      <= imm;
  end

endmodule

/* src/execute_writeback.sv */
`timescale 1ns/1ps

module execute_writeback (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   id_ex_reg_write,
  input  logic                   id_ex_alu_src,
  input  logic                   id_ex_mem_to_reg,
  input  logic                   id_ex_mem_write,
  input  logic                   id_ex_mem_read,
  input  logic                   id_ex_branch,
  input  rv_pipe_pkg::alu_op_t   id_ex_alu_op,
  input  rv_pipe_pkg::reg_addr_t id_ex_rd,
  input  logic [2:0]             id_ex_funct3,
  input  rv_pipe_pkg::word_t     id_ex_rs1_data,
  input  rv_pipe_pkg::word_t     id_ex_rs2_data,
  input  rv_pipe_pkg::word_t     id_ex_pc,
  input  rv_pipe_pkg::word_t     id_ex_imm,
  input  rv_pipe_pkg::word_t     mem_rdata,
  output logic                   branch_taken,
  output rv_pipe_pkg::word_t     branch_target,
  output rv_pipe_pkg::word_t     ex_result,
  output rv_pipe_pkg::word_t     mem_addr,
  output rv_pipe_pkg::word_t     mem_wdata,
  output rv_pipe_pkg::word_t     mem_result,
  output rv_pipe_pkg::word_t     wb_data,
  output logic                   mem_write,
  output logic                   ex_reg_write,
  output logic                   ex_mem_read,
  output logic                   mem_reg_write,
  output logic                   mem_is_load,
  output logic                   wb_we,
  output rv_pipe_pkg::reg_addr_t ex_rd,
  output rv_pipe_pkg::reg_addr_t mem_rd,
  output rv_pipe_pkg::reg_addr_t wb_rd
);

  rv_pipe_pkg::word_t alu_b;
  logic               n_flag;
  logic               z_flag;
  logic               c_flag;
  logic               v_flag;
  logic               cond;
  logic               wb_mem_to_reg;
  rv_pipe_pkg::word_t wb_result;
  rv_pipe_pkg::word_t wb_load_data;

  // ####################################################################
  // Execute
  // ####################################################################
  assign alu_b = id_ex_alu_src ? id_ex_imm : id_ex_rs2_data;

  alu u_alu (
    .a      (id_ex_rs1_data),
    .b      (alu_b),
    .alu_op (id_ex_alu_op),
    .result (ex_result),
    .n      (n_flag),
    .z      (z_flag),
    .c      (c_flag),
    .v      (v_flag)
  );

  always_comb
  begin
    case (id_ex_funct3)
      rv_pipe_pkg::F3_BEQ:  cond = z_flag;
      rv_pipe_pkg::F3_BNE:  cond = !z_flag;
      rv_pipe_pkg::F3_BLT:  cond = (n_flag != v_flag);
      rv_pipe_pkg::F3_BGE:  cond = (n_flag == v_flag);
      rv_pipe_pkg::F3_BLTU: cond = !c_flag;    // Borrow
      rv_pipe_pkg::F3_BGEU: cond = c_flag;
      default:              cond = 1'b0;
    endcase
  end

  assign branch_taken  = id_ex_branch && cond;
  assign branch_target = id_ex_pc + id_ex_imm;

  // Seen by the hazard unit
  assign ex_reg_write = id_ex_reg_write;
  assign ex_mem_read  = id_ex_mem_read;
  assign ex_rd        = id_ex_rd;

  // ####################################################################
  // EX/MEM and MEM/WB
  // ####################################################################
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mem_reg_write <= 1'b0;
      mem_is_load   <= 1'b0;
      mem_write     <= 1'b0;
      wb_we         <= 1'b0;
      wb_mem_to_reg <= 1'b0;
    end
    else
    begin
      mem_reg_write <= id_ex_reg_write;
      mem_is_load   <= id_ex_mem_to_reg;
      mem_write     <= id_ex_mem_write;
      wb_we         <= mem_reg_write;
      wb_mem_to_reg <= mem_is_load;
    end
  end

  always_ff @(posedge clk)
  begin
    mem_result   <= ex_result;
    mem_wdata    <= id_ex_rs2_data;
    mem_rd       <= id_ex_rd;
    wb_result    <= mem_result;
    wb_load_data <= mem_rdata;
    wb_rd        <= mem_rd;
  end

  assign mem_addr = mem_result;
  assign wb_data  = wb_mem_to_reg ? wb_load_data : wb_result;

  a_store_not_load: assert property (@(posedge clk) disable iff (reset)
    !(mem_write && mem_is_load));

endmodule

/* src/rv_pipe_core.sv */
`timescale 1ns/1ps

module rv_pipe_core #(
  parameter rv_pipe_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic               clk,
  input  logic               reset,
  output rv_pipe_pkg::word_t pc,
  input  rv_pipe_pkg::word_t inst,
  output logic               mem_write,
  output rv_pipe_pkg::word_t mem_addr,
  output rv_pipe_pkg::word_t mem_wdata,
  input  rv_pipe_pkg::word_t mem_rdata
);

  rv_pipe_pkg::word_t if_id_inst, if_id_pc;
  rv_pipe_pkg::word_t rs1_data, rs2_data, rf_rs1_data, rf_rs2_data;
  rv_pipe_pkg::word_t branch_target, ex_result, mem_result, wb_data;
  rv_pipe_pkg::word_t id_ex_rs1_data, id_ex_rs2_data, id_ex_pc, id_ex_imm;
  logic               stall, branch_taken;
  logic               reg_write, alu_src, mem_to_reg, dec_mem_write, mem_read, branch;
  logic [4:0]         alu_op, id_ex_alu_op;
  logic               id_ex_reg_write, id_ex_alu_src, id_ex_mem_to_reg;
  logic               id_ex_mem_write, id_ex_mem_read, id_ex_branch;
  logic [2:0]         id_ex_funct3;
  logic [4:0]         id_ex_rd, ex_rd, mem_rd, wb_rd;
  logic               ex_reg_write, ex_mem_read, mem_reg_write, mem_is_load, wb_we;

  fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
    .clk (clk), .reset (reset), .stall (stall), .branch_taken (branch_taken),
    .branch_target (branch_target), .inst (inst), .pc (pc),
    .if_id_inst (if_id_inst), .if_id_pc (if_id_pc)
  );

  inst_decoder u_dec (
    .if_id_inst (if_id_inst), .reg_write (reg_write), .alu_src (alu_src),
    .mem_to_reg (mem_to_reg), .mem_write (dec_mem_write), .mem_read (mem_read),
    .branch (branch), .alu_op (alu_op)
  );

  regfile u_rf (
    .clk (clk), .reset (reset), .we (wb_we), .rs1 (if_id_inst[19:15]),
    .rs2 (if_id_inst[24:20]), .rd (wb_rd), .rd_data (wb_data),
    .rs1_data (rf_rs1_data), .rs2_data (rf_rs2_data)
  );

  hazard_unit u_hazard (
    .if_id_inst (if_id_inst), .ex_rd (ex_rd), .mem_rd (mem_rd), .wb_rd (wb_rd),
    .ex_reg_write (ex_reg_write), .ex_mem_read (ex_mem_read),
    .mem_reg_write (mem_reg_write), .mem_is_load (mem_is_load), .wb_we (wb_we),
    .ex_result (ex_result), .mem_rdata (mem_rdata), .mem_result (mem_result),
    .wb_data (wb_data), .rf_rs1_data (rf_rs1_data), .rf_rs2_data (rf_rs2_data),
    .stall (stall), .rs1_data (rs1_data), .rs2_data (rs2_data)
  );

  decode_stage u_decode (
    .clk (clk), .reset (reset), .stall (stall), .branch_taken (branch_taken),
    .if_id_inst (if_id_inst), .if_id_pc (if_id_pc), .rs1_data (rs1_data),
    .rs2_data (rs2_data), .reg_write (reg_write), .alu_src (alu_src),
    .mem_to_reg (mem_to_reg), .mem_write (dec_mem_write), .mem_read (mem_read),
    .branch (branch), .alu_op (alu_op), .id_ex_reg_write (id_ex_reg_write),
    .id_ex_alu_src (id_ex_alu_src), .id_ex_mem_to_reg (id_ex_mem_to_reg),
    .id_ex_mem_write (id_ex_mem_write), .id_ex_mem_read (id_ex_mem_read),
    .id_ex_branch (id_ex_branch), .id_ex_alu_op (id_ex_alu_op), .id_ex_rd (id_ex_rd),
    .id_ex_funct3 (id_ex_funct3), .id_ex_rs1_data (id_ex_rs1_data),
    .id_ex_rs2_data (id_ex_rs2_data), .id_ex_pc (id_ex_pc), .id_ex_imm (id_ex_imm)
  );

  execute_writeback u_exwb (
    .clk (clk), .reset (reset), .id_ex_reg_write (id_ex_reg_write),
    .id_ex_alu_src (id_ex_alu_src), .id_ex_mem_to_reg (id_ex_mem_to_reg),
    .id_ex_mem_write (id_ex_mem_write), .id_ex_mem_read (id_ex_mem_read),
    .id_ex_branch (id_ex_branch), .id_ex_alu_op (id_ex_alu_op), .id_ex_rd (id_ex_rd),
    .id_ex_funct3 (id_ex_funct3), .id_ex_rs1_data (id_ex_rs1_data),
    .id_ex_rs2_data (id_ex_rs2_data), .id_ex_pc (id_ex_pc), .id_ex_imm (id_ex_imm),
    .mem_rdata (mem_rdata), .branch_taken (branch_taken),
    .branch_target (branch_target), .ex_result (ex_result), .mem_addr (mem_addr),
    .mem_wdata (mem_wdata), .mem_result (mem_result), .wb_data (wb_data),
    .mem_write (mem_write), .ex_reg_write (ex_reg_write), .ex_mem_read (ex_mem_read),
    .mem_reg_write (mem_reg_write), .mem_is_load (mem_is_load), .wb_we (wb_we),
    .ex_rd (ex_rd), .mem_rd (mem_rd), .wb_rd (wb_rd)
  );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;   // Released just after an edge
  end

endmodule

/* testbench/tb_rv_pipe_core.sv */
`timescale 1ns/1ps

module tb_rv_pipe_core;

  localparam rv_pipe_pkg::word_t RESET_PC = 32'h0000_0100;
  localparam int CLK_PERIOD  = 8;
  localparam int DRIVE_DELAY = 1;
  localparam int ROM_WORDS   = 128;
  localparam int RAM_WORDS   = 64;

  // Operands and the values they are expected to sign-extend to
  localparam rv_pipe_pkg::word_t A        = 32'h0000_05A5;
  localparam rv_pipe_pkg::word_t B        = 32'hFFFF_FF10;
  localparam rv_pipe_pkg::word_t MARK     = 32'h0000_004D;
  localparam rv_pipe_pkg::word_t BAD_ADDR = 32'h0000_007C;

  logic               clk;
  logic               reset;
  rv_pipe_pkg::word_t pc;
  rv_pipe_pkg::word_t inst;
  logic               mem_write;
  rv_pipe_pkg::word_t mem_addr;
  rv_pipe_pkg::word_t mem_wdata;
  rv_pipe_pkg::word_t mem_rdata;

  rv_pipe_pkg::word_t rom [ROM_WORDS];
  rv_pipe_pkg::word_t ram [RAM_WORDS];
  rv_pipe_pkg::word_t exp_addr [$];   // Expected stores, in order
  rv_pipe_pkg::word_t exp_data [$];
  int                 prog_len;
  rv_pipe_pkg::word_t end_pc;
  int                 watchdog_ns;
  logic               prog_ready = 1'b0;

  // Branch cases, x14 = -1, x15 = x16 = 1
  logic [2:0] br_f3    [12];
  int         br_rs1   [12];
  int         br_rs2   [12];
  logic       br_taken [12];

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clk_gen (
    .clk   (clk),
    .reset (reset)
  );

  rv_pipe_core #(.RESET_PC(RESET_PC)) uut (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  // ####################################################################
  // Instruction encoding
  // ####################################################################
  function automatic rv_pipe_pkg::word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                                input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_pipe_pkg::OP_R};
  endfunction

  function automatic rv_pipe_pkg::word_t i_type(input rv_pipe_pkg::opcode_t op,
                                                input logic [2:0] f3, input int rd,
                                                input int rs1, input logic [11:0] imm);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic rv_pipe_pkg::word_t s_type(input int rs2, input int rs1,
                                                input logic [11:0] imm);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], rv_pipe_pkg::OP_S};  // sw
  endfunction

  function automatic rv_pipe_pkg::word_t b_type(input logic [2:0] f3, input int rs1,
                                                input int rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], rv_pipe_pkg::OP_B};
  endfunction

  function automatic rv_pipe_pkg::word_t rom_word(input rv_pipe_pkg::word_t addr);
    rv_pipe_pkg::word_t offset;
    offset = addr - RESET_PC;
    if (offset >= rv_pipe_pkg::word_t'(4 * ROM_WORDS))
      return '0;                 // Zero word decodes as a bubble
    return rom[offset[8:2]];
  endfunction

  task automatic put(input rv_pipe_pkg::word_t word);
    rom[prog_len] = word;
    prog_len      = prog_len + 1;
  endtask

  task automatic store_and_expect(input int rs2, input rv_pipe_pkg::word_t addr,
                                  input rv_pipe_pkg::word_t data);
    put(s_type(rs2, 0, addr[11:0]));
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // ####################################################################
  // Program and expected stores
  // ####################################################################
  task automatic build_program();
    foreach (rom[i])
      rom[i] = '0;
    prog_len = 0;
    put(i_type(rv_pipe_pkg::OP_I_ARITH, 3'b000, 1, 0, A[11:0]));  // addi x1
    put(i_type(rv_pipe_pkg::OP_I_ARITH, 3'b000, 2, 0, B[11:0]));  // addi x2
    put(r_type(7'h00, 3'b000, 3, 1, 2));    // add, x2 from EX and x1 from MEM
    store_and_expect(3, 32'h00, A + B);
    put(r_type(7'h20, 3'b000, 4, 1, 2));    // sub, x2 from writeback
    store_and_expect(4, 32'h04, A - B);
    put(r_type(7'h00, 3'b111, 5, 1, 2));
    store_and_expect(5, 32'h08, A & B);
    put(r_type(7'h00, 3'b110, 6, 1, 2));
    store_and_expect(6, 32'h0C, A | B);
    put(i_type(rv_pipe_pkg::OP_I_ARITH, 3'b100, 7, 1, 12'h33C));  // xori
    put(i_type(rv_pipe_pkg::OP_I_ARITH, 3'b110, 8, 1, 12'h8F0));  // ori, negative imm
    store_and_expect(7, 32'h10, A ^ 32'h0000_033C);
    store_and_expect(8, 32'h14, A | 32'hFFFF_F8F0);
    put(i_type(rv_pipe_pkg::OP_I_ARITH, 3'b111, 9, 1, 12'h0F0));  // andi
    put(i_type(rv_pipe_pkg::OP_I_ARITH, 3'b001, 10, 1, 12'h007)); // slli by 7
    store_and_expect(9, 32'h18, A & 32'h0000_00F0);
    store_and_expect(10, 32'h1C, A << 7);
    store_and_expect(2, 32'h20, B);
    // Load followed by its consumer
    put(i_type(rv_pipe_pkg::OP_I_LOAD, 3'b010, 11, 0, 12'h000));
    put(i_type(rv_pipe_pkg::OP_I_ARITH, 3'b000, 12, 11, 12'h001));
    store_and_expect(12, 32'h24, A + B + 32'd1);
    put(i_type(rv_pipe_pkg::OP_I_LOAD, 3'b010, 13, 0, 12'h004));
    store_and_expect(13, 32'h28, A - B);    // Store data straight from a load
    put(i_type(rv_pipe_pkg::OP_I_ARITH, 3'b000, 0, 0, 12'h7FF));  // Write to x0
    store_and_expect(0, 32'h2C, 32'h0);
    put(i_type(rv_pipe_pkg::OP_I_ARITH, 3'b000, 17, 0, 12'h7AD));
    put(i_type(rv_pipe_pkg::OP_I_ARITH, 3'b000, 18, 0, MARK[11:0]));
    put(i_type(rv_pipe_pkg::OP_I_ARITH, 3'b000, 14, 0, 12'hFFF));
    put(i_type(rv_pipe_pkg::OP_I_ARITH, 3'b000, 15, 0, 12'h001));
    put(i_type(rv_pipe_pkg::OP_I_ARITH, 3'b000, 16, 0, 12'h001));
    br_f3 = '{rv_pipe_pkg::F3_BEQ, rv_pipe_pkg::F3_BEQ, rv_pipe_pkg::F3_BNE,
              rv_pipe_pkg::F3_BNE, rv_pipe_pkg::F3_BLT, rv_pipe_pkg::F3_BLT,
              rv_pipe_pkg::F3_BGE, rv_pipe_pkg::F3_BGE, rv_pipe_pkg::F3_BLTU,
              rv_pipe_pkg::F3_BLTU, rv_pipe_pkg::F3_BGEU, rv_pipe_pkg::F3_BGEU};
    br_rs1   = '{15, 14, 14, 15, 14, 15, 15, 14, 15, 14, 14, 15};
    br_rs2   = '{16, 15, 15, 16, 15, 14, 14, 15, 14, 15, 15, 14};
    br_taken = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
    foreach (br_f3[i])
    begin
      if (br_taken[i])
      begin
        put(b_type(br_f3[i], br_rs1[i], br_rs2[i], 13'd12));  // Over two wrong-path stores
        put(s_type(17, 0, BAD_ADDR[11:0]));
        put(s_type(17, 0, BAD_ADDR[11:0]));
      end
      else
      begin
        put(b_type(br_f3[i], br_rs1[i], br_rs2[i], 13'd8));
        store_and_expect(18, 32'h40 + 32'(4 * i), MARK);
      end
    end
    end_pc = RESET_PC + rv_pipe_pkg::word_t'(4 * prog_len);
    put(b_type(rv_pipe_pkg::F3_BEQ, 0, 0, 13'h0));  // Self-loop
    watchdog_ns = (exp_addr.size() + 1) * 40 * CLK_PERIOD;
  endtask

  // ####################################################################
  // Memory models
  // ####################################################################
  initial
  begin
    inst      = '0;
    mem_rdata = '0;
    foreach (ram[i])
      ram[i] = {16'hDA7A, 16'(i)};
    forever
    begin
      @(posedge clk);
      #(DRIVE_DELAY);
      if (mem_write)
        ram[mem_addr[7:2]] = mem_wdata;
      inst      = rom_word(pc);
      mem_rdata = ram[mem_addr[7:2]];
    end
  end

  // ####################################################################
  // Checks
  // ####################################################################
  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic value_error(input string name, input rv_pipe_pkg::word_t expected,
                             input rv_pipe_pkg::word_t actual);
    $display("error: time %0t %s expected %h actual %h", $time, name, expected, actual);
    abort_run();
  endtask

  task automatic report_failure(input string what);
    $display("%s (time %0t)", what, $time);
    abort_run();
  endtask

  initial
  begin
    build_program();
    prog_ready = 1'b1;
    @(negedge reset);
    #(DRIVE_DELAY);
    assert (pc == RESET_PC) else value_error("pc", RESET_PC, pc);
    assert (!mem_write) else report_failure("mem_write is high right after reset");
    foreach (exp_addr[i])
    begin
      do
      begin
        @(posedge clk);
        #(DRIVE_DELAY);
      end
      while (!mem_write);
      assert (mem_addr == exp_addr[i]) else value_error("mem_addr", exp_addr[i], mem_addr);
      assert (mem_wdata == exp_data[i]) else value_error("mem_wdata", exp_data[i], mem_wdata);
    end
    while (pc != end_pc)
    begin
      @(posedge clk);
      #(DRIVE_DELAY);
      assert (!mem_write) else report_failure("A store followed the last expected store");
    end
    // The loop keeps cycling over its two flushed slots
    repeat (12)
    begin
      @(posedge clk);
      #(DRIVE_DELAY);
      assert (!mem_write) else report_failure("A store was issued inside the final loop");
      assert (pc >= end_pc && pc <= end_pc + 32'd8)
      else report_failure("The pc left the final self-loop");
    end
    $display("*** PASSED ***");
    $finish;
  end

  initial
  begin
    wait (prog_ready);
    #(watchdog_ns);
    report_failure("Timeout, the program did not reach its final loop in time");
  end

endmodule

/* rv_pipe.f */
src/rv_pipe_pkg.sv
src/alu.sv
src/inst_decoder.sv
src/regfile.sv
src/hazard_unit.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_writeback.sv
src/rv_pipe_core.sv
testbench/tb_clock_gen.sv
testbench/tb_rv_pipe_core.sv

/* run_sim.sh */
#!/bin/sh
# Compile the pipelined core with its testbench in Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rv_pipe_core -f rv_pipe.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit 1
fi

exit 0
